/* Bender.yml */
package:
  name: conv_layer

export_include_dirs:
  - hw

sources:
  - hw/conv_layer_pkg.sv
  - hw/coeff_store.sv
  - hw/mac_lane.sv
  - hw/conv_sequencer.sv
  - hw/relu_requant.sv
  - hw/wb_ctrl_regs.sv
  - hw/conv_layer_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_conv_layer.sv

/* dv/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	// Reset held for 16 rising edges
	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

/* dv/tb_conv_layer.sv */
`timescale 1ns/100ps
`include "conv_layer_macros.svh"

module tb_conv_layer;

	localparam int LANES = `CONV_LANES;
	localparam int TAPS = `CONV_TAPS;
	localparam int PIXELS = `CONV_OUT_PIXELS;
	localparam int COEF_WORDS = LANES * TAPS + LANES;
	// Two coefficient loads plus status and readback traffic
	localparam int BUS_CYCLES = (2 * COEF_WORDS + 40) * 4;
	// Two layers plus one group of extra pixels each
	localparam int STREAM_CYCLES = 2 * (PIXELS + 1) * TAPS * 4;
	localparam int MAX_CYCLES = 200 + BUS_CYCLES + STREAM_CYCLES + 200;

	logic clk;
	logic rst_n;
	conv_layer_pkg::wb_req_s wb_req;
	conv_layer_pkg::wb_rsp_s wb_rsp;
	logic pixel_valid;
	logic [`CONV_DATA_W-1:0] pixel;
	logic ram_feedback;
	conv_layer_pkg::ofm_vec_s ofm;
	logic ofm_sample;
	logic finish;

	// Coefficients as loaded into the DUT
	logic [15:0] wt_tab [LANES][TAPS];
	logic [31:0] bias_tab [LANES];
	// Stimulus and expected lane outputs with one row per output pixel
	logic [15:0] pix_tab [PIXELS][TAPS];
	logic [15:0] exp_tab [PIXELS][LANES];
	conv_layer_pkg::ofm_vec_s got_q [$];
	logic [31:0] rdata;
	int seed = 37;
	int cycle_cnt = 0;

	tb_clk_gen u_clk_gen (
		.clk(clk),
		.rst_n(rst_n)
	);

	conv_layer_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.pixel_valid(pixel_valid),
		.pixel(pixel),
		.ram_feedback(ram_feedback),
		.ofm(ofm),
		.ofm_sample(ofm_sample),
		.finish(finish)
	);

	//////////////////////////////////////////////////////////////////////
	// Checks, bus access and reference model
	//////////////////////////////////////////////////////////////////////
	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Ack sampled as it stood before the edge
	task automatic wait_ack;
		@(posedge clk);
		while (!wb_rsp.ack) begin
			@(posedge clk);
		end
	endtask

	task automatic bus_write(input logic [7:0] adr, input logic [31:0] data);
		@(posedge clk);
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we <= 1'b1;
		wb_req.adr <= adr;
		wb_req.dat <= data;
		wait_ack();
		// stb low at least one cycle before the next transfer
		wb_req.cyc <= 1'b0;
		wb_req.stb <= 1'b0;
		wb_req.we <= 1'b0;
	endtask

	task automatic bus_read(input logic [7:0] adr, output logic [31:0] data);
		@(posedge clk);
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we <= 1'b0;
		wb_req.adr <= adr;
		wait_ack();
		data = wb_rsp.dat;
		wb_req.cyc <= 1'b0;
		wb_req.stb <= 1'b0;
	endtask

	// Pixel times weight summed with the bias before ReLU and Q14 rescale
	function automatic logic [15:0] ref_out(input int row, input int lane);
		logic signed [31:0] acc;
		acc = bias_tab[lane];
		for (int t = 0; t < TAPS; t++) begin
			acc = acc + $signed(pix_tab[row][t]) * $signed(wt_tab[lane][t]);
		end
		if (acc < 0) begin
			return 16'h0000;
		end
		return 16'((acc >>> `CONV_FRAC) & 32'h7fff);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Coefficient load and stimulus table
	//////////////////////////////////////////////////////////////////////
	task automatic program_coeffs(input int layer);
		int role;
		logic [15:0] w;
		for (int l = 0; l < LANES; l++) begin
			// Lane role rotates from layer to layer
			role = (l + layer) % LANES;
			for (int t = 0; t < TAPS; t++) begin
				case (role)
					// All negative to drive the sum below zero
					0: w = -16'(($random(seed) & 32'h7ff) + 64);
					3: w = 16'($random(seed) % 256);
					default: w = 16'($random(seed) % 4096);
				endcase
				wt_tab[l][t] = w;
				bus_write(8'(`CONV_ADR_WEIGHT + l * TAPS + t), {{16{w[15]}}, w});
			end
			case (role)
				0: bias_tab[l] = $random(seed) % 4096;
				// Bias dominated lane
				3: bias_tab[l] = 32'h0200_0000 + ($random(seed) & 32'hffff);
				default: bias_tab[l] = $random(seed) % (1 << 20);
			endcase
			bus_write(8'(`CONV_ADR_BIAS + l), bias_tab[l]);
		end
	endtask

	// First and last tap of each lane and then the bias
	task automatic readback_coeffs;
		logic [31:0] data;
		for (int l = 0; l < LANES; l++) begin
			bus_read(8'(`CONV_ADR_WEIGHT + l * TAPS), data);
			check_val("weight tap 0", data, {{16{wt_tab[l][0][15]}}, wt_tab[l][0]});
			bus_read(8'(`CONV_ADR_WEIGHT + l * TAPS + TAPS - 1), data);
			check_val("weight last tap", data,
				{{16{wt_tab[l][TAPS-1][15]}}, wt_tab[l][TAPS-1]});
			bus_read(8'(`CONV_ADR_BIAS + l), data);
			check_val("bias", data, bias_tab[l]);
		end
	endtask

	task automatic build_table;
		for (int r = 0; r < PIXELS; r++) begin
			for (int t = 0; t < TAPS; t++) begin
				// Row 0 gives bias only and row 1 full scale
				if (r == 0) begin
					pix_tab[r][t] = 16'h0000;
				end else if (r == 1) begin
					pix_tab[r][t] = 16'h0fff;
				end else begin
					pix_tab[r][t] = 16'($random(seed) & 32'hfff);
				end
			end
			for (int l = 0; l < LANES; l++) begin
				exp_tab[r][l] = ref_out(r, l);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Pixel stream and result collection
	//////////////////////////////////////////////////////////////////////
	// All rows back to back so groups overlap in the pipeline
	task automatic stream_layer;
		for (int r = 0; r < PIXELS; r++) begin
			for (int t = 0; t < TAPS; t++) begin
				@(posedge clk);
				pixel_valid <= 1'b1;
				pixel <= pix_tab[r][t];
			end
		end
		@(posedge clk);
		pixel_valid <= 1'b0;
	endtask

	// One more group offered after the layer end
	task automatic send_extra;
		for (int t = 0; t < TAPS; t++) begin
			@(posedge clk);
			pixel_valid <= 1'b1;
			pixel <= 16'($random(seed) & 32'hfff);
		end
		@(posedge clk);
		pixel_valid <= 1'b0;
	endtask

	task automatic wait_samples(input int n);
		while (got_q.size() < n) begin
			@(posedge clk);
		end
	endtask

	task automatic compare_layer;
		conv_layer_pkg::ofm_vec_s got;
		check_val("ofm_sample count", got_q.size(), PIXELS);
		for (int r = 0; r < PIXELS; r++) begin
			got = got_q.pop_front();
			for (int l = 0; l < LANES; l++) begin
				check_val($sformatf("ofm.ch[%0d] row %0d", l, r),
					got.ch[l], exp_tab[r][l]);
			end
		end
	endtask

	task automatic pulse_feedback;
		@(posedge clk);
		ram_feedback <= 1'b1;
		@(posedge clk);
		ram_feedback <= 1'b0;
		@(posedge clk);
	endtask

	// Output vector taken in its sample cycle
	always @(posedge clk) begin
		if (rst_n && ofm_sample) begin
			got_q.push_back(ofm);
		end
	end

	// Run limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT never completed the test",
				cycle_cnt);
			$display("*** FAILED ***");
			$fatal(1, "Run aborted");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		wb_req = '0;
		pixel_valid = 1'b0;
		pixel = '0;
		ram_feedback = 1'b0;
		@(posedge rst_n);
		@(posedge clk);
		// Idle after reset
		check_val("finish", finish, 0);
		check_val("ofm_sample", ofm_sample, 0);
		bus_read(`CONV_ADR_STATUS, rdata);
		check_val("STATUS", rdata, 0);
		bus_read(`CONV_ADR_CTRL, rdata);
		check_val("CTRL", rdata, 0);
		bus_read(8'hf0, rdata);
		check_val("unmapped word", rdata, 0);
		bus_read(`CONV_ADR_WEIGHT, rdata);
		check_val("weight after reset", rdata, 0);
		for (int layer = 0; layer < 2; layer++) begin
			program_coeffs(layer);
			readback_coeffs();
			build_table();
			bus_write(`CONV_ADR_CTRL, 32'h1);
			// Start clears the flags of the previous layer
			bus_read(`CONV_ADR_STATUS, rdata);
			check_val("STATUS running", rdata, 32'h1);
			stream_layer();
			wait_samples(PIXELS);
			check_val("finish at layer end", finish, 1);
			send_extra();
			repeat (8) @(posedge clk);
			compare_layer();
			bus_read(`CONV_ADR_STATUS, rdata);
			check_val("STATUS done", rdata, 32'h6);
			pulse_feedback();
			check_val("finish after ram_feedback", finish, 0);
			bus_read(`CONV_ADR_STATUS, rdata);
			check_val("STATUS released", rdata, 32'h2);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* hw/coeff_store.sv */
`timescale 1ns/100ps
`include "conv_layer_macros.svh"

module coeff_store (
	input  logic clk,
	input  logic rst_n,
	input  logic coef_we,
	input  logic coef_bias,
	input  logic [`CONV_LANE_W-1:0] coef_lane,
	input  logic [`CONV_TAP_W-1:0] coef_tap,
	input  logic [`CONV_WB_DW-1:0] coef_wdata,
	output logic [`CONV_WB_DW-1:0] coef_rdata,
	input  logic [`CONV_TAP_W-1:0] tap_addr,
	output logic [`CONV_LANES-1:0][`CONV_DATA_W-1:0] weights,
	output logic [`CONV_LANES-1:0][`CONV_ACC_W-1:0] biases
);

	// Weight words per lane and tap
	logic [`CONV_DATA_W-1:0] wmem [`CONV_LANES][`CONV_TAPS];
	// Bias word per lane
	logic [`CONV_ACC_W-1:0] bmem [`CONV_LANES];
	logic [`CONV_DATA_W-1:0] wsel;

	// Coefficients come up as zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int l = 0; l < `CONV_LANES; l++) begin
				bmem[l] <= '0;
				for (int t = 0; t < `CONV_TAPS; t++) begin
					wmem[l][t] <= '0;
				end
			end
			weights <= '0;
		end else begin
			// Bus write
			if (coef_we) begin
				if (coef_bias) begin
					bmem[coef_lane] <= coef_wdata;
				end else begin
					wmem[coef_lane][coef_tap] <= coef_wdata[`CONV_DATA_W-1:0];
				end
			end
			// Lane read of all lanes at one tap
			for (int l = 0; l < `CONV_LANES; l++) begin
				weights[l] <= wmem[l][tap_addr];
			end
		end
	end

	// Biases go straight to the output stage
	always_comb begin
		for (int l = 0; l < `CONV_LANES; l++) begin
			biases[l] = bmem[l];
		end
	end

	// Bus read port
	// weight comes back sign extended to the bus word
	assign wsel = wmem[coef_lane][coef_tap];
	assign coef_rdata = coef_bias ? bmem[coef_lane] :
		{{(`CONV_WB_DW-`CONV_DATA_W){wsel[`CONV_DATA_W-1]}}, wsel};

endmodule

/* hw/conv_layer_macros.svh */
`ifndef CONV_LAYER_MACROS_SVH
`define CONV_LAYER_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Layer geometry
//////////////////////////////////////////////////////////////////////
// Parallel output channels
`define CONV_LANES 4
// 3x3 kernel over 2 input channels
`define CONV_TAPS 18
`define CONV_OUT_PIXELS 6

// Datapath widths
`define CONV_DATA_W 16
`define CONV_ACC_W 32
// Q14 fraction dropped on rescale
`define CONV_FRAC 14
`define CONV_LANE_W 2
`define CONV_TAP_W 5
`define CONV_PIX_W 3

// Wishbone widths
`define CONV_WB_AW 8
`define CONV_WB_DW 32

//////////////////////////////////////////////////////////////////////
// Register map in word addresses
//////////////////////////////////////////////////////////////////////
`define CONV_ADR_CTRL 8'h00
`define CONV_ADR_STATUS 8'h01
// Weight word at base + lane * CONV_TAPS + tap
`define CONV_ADR_WEIGHT 8'h10
// One bias word per lane
`define CONV_ADR_BIAS 8'h60

`endif

/* hw/conv_layer_pkg.sv */
`include "conv_layer_macros.svh"

package conv_layer_pkg;

	//////////////////////////////////////////////////////////////////////
	// Wishbone classic bus
	//////////////////////////////////////////////////////////////////////
	// Master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`CONV_WB_AW-1:0] adr;
		logic [`CONV_WB_DW-1:0] dat;
	} wb_req_s;

	// Slave to master
	typedef struct packed {
		logic ack;
		logic [`CONV_WB_DW-1:0] dat;
	} wb_rsp_s;

	//////////////////////////////////////////////////////////////////////
	// Datapath and control types
	//////////////////////////////////////////////////////////////////////
	// One output pixel with an entry per lane
	typedef struct packed {
		logic [`CONV_LANES-1:0][`CONV_DATA_W-1:0] ch;
	} ofm_vec_s;

	// Layer sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_DONE
	} conv_state_e;

	// Decoded bus target
	typedef enum logic [2:0] {
		REG_CTRL,
		REG_STATUS,
		REG_WEIGHT,
		REG_BIAS,
		REG_NONE
	} reg_sel_e;

endpackage

/* hw/conv_layer_top.sv */
`timescale 1ns/100ps
`include "conv_layer_macros.svh"

module conv_layer_top (
	input  logic clk,
	input  logic rst_n,
	input  conv_layer_pkg::wb_req_s wb_req,
	output conv_layer_pkg::wb_rsp_s wb_rsp,
	input  logic pixel_valid,
	input  logic [`CONV_DATA_W-1:0] pixel,
	input  logic ram_feedback,
	output conv_layer_pkg::ofm_vec_s ofm,
	output logic ofm_sample,
	output logic finish
);

	// Coefficient write and readback
	logic coef_we;
	logic coef_bias;
	logic [`CONV_LANE_W-1:0] coef_lane;
	logic [`CONV_TAP_W-1:0] coef_tap;
	logic [`CONV_WB_DW-1:0] coef_wdata;
	logic [`CONV_WB_DW-1:0] coef_rdata;
	// Sequencer control
	logic start;
	logic running;
	logic layer_end;
	logic [`CONV_DATA_W-1:0] pixel_q;
	logic [`CONV_TAP_W-1:0] tap_addr;
	logic acc_en;
	logic acc_clr;
	logic group_done;
	// Lane datapath
	logic [`CONV_LANES-1:0][`CONV_DATA_W-1:0] weights;
	logic [`CONV_LANES-1:0][`CONV_ACC_W-1:0] biases;
	logic [`CONV_LANES-1:0][`CONV_ACC_W-1:0] sums;

	wb_ctrl_regs u_wb_ctrl_regs (
		.clk(clk),
		.rst_n(rst_n),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.coef_we(coef_we),
		.coef_bias(coef_bias),
		.coef_lane(coef_lane),
		.coef_tap(coef_tap),
		.coef_wdata(coef_wdata),
		.coef_rdata(coef_rdata),
		.start(start),
		.running(running),
		.layer_end(layer_end),
		.finish(finish)
	);

	coeff_store u_coeff_store (
		.clk(clk),
		.rst_n(rst_n),
		.coef_we(coef_we),
		.coef_bias(coef_bias),
		.coef_lane(coef_lane),
		.coef_tap(coef_tap),
		.coef_wdata(coef_wdata),
		.coef_rdata(coef_rdata),
		.tap_addr(tap_addr),
		.weights(weights),
		.biases(biases)
	);

	conv_sequencer u_conv_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.pixel_valid(pixel_valid),
		.pixel(pixel),
		.ram_feedback(ram_feedback),
		.pixel_q(pixel_q),
		.tap_addr(tap_addr),
		.acc_en(acc_en),
		.acc_clr(acc_clr),
		.group_done(group_done),
		.running(running),
		.layer_end(layer_end),
		.finish(finish)
	);

	//////////////////////////////////////////////////////////////////////
	// MAC lanes sharing one pixel
	//////////////////////////////////////////////////////////////////////
	for (genvar g = 0; g < `CONV_LANES; g++) begin : g_lane
		mac_lane u_mac_lane (
			.clk(clk),
			.rst_n(rst_n),
			.acc_en(acc_en),
			.acc_clr(acc_clr),
			.pixel_q(pixel_q),
			.weight(weights[g]),
			.sum(sums[g])
		);
	end

	relu_requant u_relu_requant (
		.clk(clk),
		.rst_n(rst_n),
		.group_done(group_done),
		.sums(sums),
		.biases(biases),
		.ofm(ofm),
		.ofm_sample(ofm_sample)
	);

endmodule

/* hw/conv_sequencer.sv */
`timescale 1ns/100ps
`include "conv_layer_macros.svh"

module conv_sequencer (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic pixel_valid,
	input  logic [`CONV_DATA_W-1:0] pixel,
	input  logic ram_feedback,
	output logic [`CONV_DATA_W-1:0] pixel_q,
	output logic [`CONV_TAP_W-1:0] tap_addr,
	output logic acc_en,
	output logic acc_clr,
	output logic group_done,
	output logic running,
	output logic layer_end,
	output logic finish
);

	conv_layer_pkg::conv_state_e state;
	logic [`CONV_TAP_W-1:0] tap_cnt;
	logic [`CONV_PIX_W-1:0] pix_cnt;
	logic take;
	logic last_tap;
	logic last_pix;
	// Consume stage
	logic [`CONV_DATA_W-1:0] pixel_r;
	logic tap_vld;
	logic tap_first;
	logic tap_last;
	// Accumulate stage
	logic acc_last;

	assign running = (state == conv_layer_pkg::SEQ_RUN);
	// One pixel per valid cycle without back-pressure
	assign take = running & pixel_valid;
	assign last_tap = (tap_cnt == `CONV_TAPS - 1);
	assign last_pix = (pix_cnt == `CONV_OUT_PIXELS - 1);

	//////////////////////////////////////////////////////////////////////
	// Layer FSM with tap and pixel counters
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= conv_layer_pkg::SEQ_IDLE;
			tap_cnt <= '0;
			pix_cnt <= '0;
			layer_end <= 1'b0;
			finish <= 1'b0;
		end else begin
			case (state)
				conv_layer_pkg::SEQ_IDLE,
				conv_layer_pkg::SEQ_DONE: begin
					// Restart clears every count and flag
					if (start) begin
						state <= conv_layer_pkg::SEQ_RUN;
						tap_cnt <= '0;
						pix_cnt <= '0;
						layer_end <= 1'b0;
						finish <= 1'b0;
					end else if (finish && ram_feedback) begin
						// Downstream memory has taken the layer
						finish <= 1'b0;
					end
				end
				conv_layer_pkg::SEQ_RUN: begin
					if (pixel_valid) begin
						if (last_tap) begin
							tap_cnt <= '0;
							pix_cnt <= pix_cnt + 1'b1;
							// Last group of the layer
							if (last_pix) begin
								state <= conv_layer_pkg::SEQ_DONE;
								layer_end <= 1'b1;
								finish <= 1'b1;
							end
						end else begin
							tap_cnt <= tap_cnt + 1'b1;
						end
					end
				end
				default: state <= conv_layer_pkg::SEQ_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pulse pipeline matched to the store read latency
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tap_addr <= '0;
			tap_vld <= 1'b0;
			tap_first <= 1'b0;
			tap_last <= 1'b0;
			acc_en <= 1'b0;
			acc_clr <= 1'b0;
			acc_last <= 1'b0;
			group_done <= 1'b0;
		end else begin
			// Address for the weight read
			if (take) begin
				tap_addr <= tap_cnt;
			end
			tap_vld <= take;
			tap_first <= take & (tap_cnt == '0);
			tap_last <= take & last_tap;
			// Weights arrive with these
			acc_en <= tap_vld;
			acc_clr <= tap_first;
			acc_last <= tap_last;
			// Sum is complete after the last accumulate
			group_done <= acc_en & acc_last;
		end
	end

	// Pixel travels beside the accumulate pulse
	always_ff @(posedge clk) begin
		if (take) begin
			pixel_r <= pixel;
		end
		pixel_q <= pixel_r;
	end

endmodule

/* hw/mac_lane.sv */
`timescale 1ns/100ps
`include "conv_layer_macros.svh"

module mac_lane (
	input  logic clk,
	input  logic rst_n,
	input  logic acc_en,
	input  logic acc_clr,
	input  logic [`CONV_DATA_W-1:0] pixel_q,
	input  logic [`CONV_DATA_W-1:0] weight,
	output logic [`CONV_ACC_W-1:0] sum
);

	// Signed 16x16 product at full width
	logic signed [`CONV_ACC_W-1:0] prod;

	assign prod = $signed(pixel_q) * $signed(weight);

	// Accumulator wraps on overflow
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum <= '0;
		end else if (acc_en) begin
			// First tap of a group starts a fresh sum
			if (acc_clr) begin
				sum <= prod;
			end else begin
				sum <= sum + prod;
			end
		end
	end

endmodule

/* hw/relu_requant.sv */
`timescale 1ns/100ps
`include "conv_layer_macros.svh"

module relu_requant (
	input  logic clk,
	input  logic rst_n,
	input  logic group_done,
	input  logic [`CONV_LANES-1:0][`CONV_ACC_W-1:0] sums,
	input  logic [`CONV_LANES-1:0][`CONV_ACC_W-1:0] biases,
	output conv_layer_pkg::ofm_vec_s ofm,
	output logic ofm_sample
);

	// Biased sums of the last finished group
	logic [`CONV_LANES-1:0][`CONV_ACC_W-1:0] biased_q;
	logic biased_vld;

	// Capture before the next group clears the lanes
	always_ff @(posedge clk) begin
		if (group_done) begin
			for (int l = 0; l < `CONV_LANES; l++) begin
				biased_q[l] <= sums[l] + biases[l];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// ReLU and Q14 rescale into the output register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (biased_vld) begin
			for (int l = 0; l < `CONV_LANES; l++) begin
				// Negative sum clamps to zero
				if (biased_q[l][`CONV_ACC_W-1]) begin
					ofm.ch[l] <= '0;
				end else begin
					// Truncating shift with the top bit kept zero
					ofm.ch[l] <= {1'b0,
						biased_q[l][`CONV_FRAC+`CONV_DATA_W-2:`CONV_FRAC]};
				end
			end
		end
	end

	// Sample pulse follows the data by stage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			biased_vld <= 1'b0;
			ofm_sample <= 1'b0;
		end else begin
			biased_vld <= group_done;
			ofm_sample <= biased_vld;
		end
	end

endmodule

/* hw/wb_ctrl_regs.sv */
`timescale 1ns/100ps
`include "conv_layer_macros.svh"

module wb_ctrl_regs (
	input  logic clk,
	input  logic rst_n,
	input  conv_layer_pkg::wb_req_s wb_req,
	output conv_layer_pkg::wb_rsp_s wb_rsp,
	output logic coef_we,
	output logic coef_bias,
	output logic [`CONV_LANE_W-1:0] coef_lane,
	output logic [`CONV_TAP_W-1:0] coef_tap,
	output logic [`CONV_WB_DW-1:0] coef_wdata,
	input  logic [`CONV_WB_DW-1:0] coef_rdata,
	output logic start,
	input  logic running,
	input  logic layer_end,
	input  logic finish
);

	conv_layer_pkg::reg_sel_e sel;
	// Request seen but not yet acked
	logic req;
	logic ack_q;
	logic [`CONV_WB_DW-1:0] rdata_q;
	logic [`CONV_WB_DW-1:0] rdata_mux;
	logic [`CONV_WB_DW-1:0] status;
	// Offsets into the coefficient regions
	logic [`CONV_WB_AW-1:0] w_off;
	logic [`CONV_WB_AW-1:0] b_off;
	logic [`CONV_WB_AW-1:0] w_lane;
	logic [`CONV_WB_AW-1:0] w_tap;

	assign req = wb_req.cyc & wb_req.stb & ~ack_q;

	//////////////////////////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		sel = conv_layer_pkg::REG_NONE;
		if (wb_req.adr == `CONV_ADR_CTRL) begin
			sel = conv_layer_pkg::REG_CTRL;
		end else if (wb_req.adr == `CONV_ADR_STATUS) begin
			sel = conv_layer_pkg::REG_STATUS;
		end else if (wb_req.adr >= `CONV_ADR_WEIGHT &&
				wb_req.adr < `CONV_ADR_WEIGHT + `CONV_LANES * `CONV_TAPS) begin
			sel = conv_layer_pkg::REG_WEIGHT;
		end else if (wb_req.adr >= `CONV_ADR_BIAS &&
				wb_req.adr < `CONV_ADR_BIAS + `CONV_LANES) begin
			sel = conv_layer_pkg::REG_BIAS;
		end
	end

	// Weight offset splits into lane and tap
	assign w_off = wb_req.adr - `CONV_ADR_WEIGHT;
	assign b_off = wb_req.adr - `CONV_ADR_BIAS;
	assign w_lane = 8'(w_off / `CONV_TAPS);
	assign w_tap = 8'(w_off % `CONV_TAPS);

	// Coefficient port
	assign coef_bias = (sel == conv_layer_pkg::REG_BIAS);
	assign coef_lane = coef_bias ? b_off[`CONV_LANE_W-1:0] : w_lane[`CONV_LANE_W-1:0];
	assign coef_tap = w_tap[`CONV_TAP_W-1:0];
	assign coef_wdata = wb_req.dat;
	assign coef_we = req & wb_req.we &
		(sel == conv_layer_pkg::REG_WEIGHT || sel == conv_layer_pkg::REG_BIAS);

	// Start bit is a one-cycle command
	assign start = req & wb_req.we & (sel == conv_layer_pkg::REG_CTRL) & wb_req.dat[0];

	//////////////////////////////////////////////////////////////////////
	// Read path and ack
	//////////////////////////////////////////////////////////////////////
	assign status = {{(`CONV_WB_DW-3){1'b0}}, finish, layer_end, running};

	// CTRL and unmapped words read zero
	always_comb begin
		case (sel)
			conv_layer_pkg::REG_STATUS: rdata_mux = status;
			conv_layer_pkg::REG_WEIGHT,
			conv_layer_pkg::REG_BIAS: rdata_mux = coef_rdata;
			default: rdata_mux = '0;
		endcase
	end

	// Ack one cycle after the request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req;
		end
	end

	// Read data held for the ack cycle
	always_ff @(posedge clk) begin
		if (req) begin
			rdata_q <= rdata_mux;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rdata_q;

endmodule

/* src.f */
+incdir+hw
hw/conv_layer_pkg.sv
hw/coeff_store.sv
hw/mac_lane.sv
hw/conv_sequencer.sv
hw/relu_requant.sv
hw/wb_ctrl_regs.sv
hw/conv_layer_top.sv
dv/tb_clk_gen.sv
dv/tb_conv_layer.sv
